//--- list.f
cp0RegPkg.sv
trapPkg.sv
cp0Decode.sv
cp0Timer.sv
cp0ExcState.sv
cp0ReadMux.sv
cp0Top.sv
tbCp0.sv

//--- run.sh
#!/bin/bash
# Build the testbench with Verilator and run it, pass or fail comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tbCp0 -f list.f -o simCp0 > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simCp0 > sim.log 2>&1 || { echo "Simulation exited with an error"; exit 1; }

grep -q "Testbench failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0

//--- tbCp0.sv
`timescale 1ns/1ps

module tbCp0 import cp0RegPkg::*, trapPkg::*; ();

    localparam int writeRounds  = 40;
    localparam int countSteps   = 6;
    localparam int timerWaitMax = 24;
    localparam int excRounds    = 30;
    localparam int intRounds    = 30;
    // Edges used by each test plus a margin
    localparam int cycleLimit = 16 + 8 + 2 * writeRounds + (4 + 2 * countSteps)
                              + (6 + timerWaitMax) + (10 + 2 * excRounds) + 2 * intRounds + 50;

    logic         clk;
    logic         reset;
    cp0WriteT     wrReq;
    excReqT       excReq;
    intLinesT     intLines;
    regAddrT      rdAddr;
    word32T       rdData;
    statusFieldsT status;
    causeFieldsT  cause;
    word32T       epc;

    // Reference model
    statusFieldsT mStatus;
    causeFieldsT  mCause;
    word32T       mEpc;
    word32T       mBadVAddr;
    word32T       mCount;
    word32T       mCompare;
    logic         mPhase;

    int errCount;
    int testErrors;
    int passTests;
    int failTests;
    int checkCount;
    int cycleCount;

    regAddrT implAddrs [6] = '{addrBadVAddr, addrCount, addrCompare, addrStatus, addrCause,
                               addrEpc};

    cp0Top i_cp0Top (
        .clk      (clk),
        .reset    (reset),
        .wrReq    (wrReq),
        .excReq   (excReq),
        .intLines (intLines),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .status   (status),
        .cause    (cause),
        .epc      (epc)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic excCodeT codeFor(excTypeT t);
        case (t)
            excAddrFetch, excAddrLoad: return codeAdEL;
            excAddrStore:              return codeAdES;
            excReserved:               return codeRi;
            excSyscall:                return codeSys;
            excBreak:                  return codeBp;
            excTrap:                   return codeTr;
            excOverflow:               return codeOv;
            default:                   return codeInt;
        endcase
    endfunction

    always @(posedge clk) begin : refModel
        logic hit;
        logic enter;
        logic leave;
        logic wrOn;
        if (reset) begin
            mStatus   <= {1'b1, 8'h00, 2'b00};   // Only bev set
            mCause    <= '0;
            mEpc      <= '0;
            mBadVAddr <= '0;
            mCount    <= 32'd0;
            mCompare  <= 32'hffff_ffff;
            mPhase    <= 1'b0;
        end else begin
            hit   = (mCount == mCompare);
            wrOn  = wrReq.valid;
            enter = excReq.valid && (excReq.excType != excEret);
            leave = excReq.valid && (excReq.excType == excEret);

            if (wrOn && wrReq.addr == addrCount) begin
                mCount <= wrReq.data;
                mPhase <= 1'b0;
            end else begin
                mPhase <= ~mPhase;
                if (mPhase) mCount <= mCount + 32'd1;
            end
            if (wrOn && wrReq.addr == addrCompare) mCompare <= wrReq.data;

            if (wrOn && wrReq.addr == addrStatus) begin
                mStatus.bev <= wrReq.data[22];
                mStatus.im  <= wrReq.data[15:8];
                mStatus.ie  <= wrReq.data[0];
            end
            if (enter) mStatus.exl <= 1'b1;
            else if (leave) mStatus.exl <= 1'b0;
            else if (wrOn && wrReq.addr == addrStatus) mStatus.exl <= wrReq.data[1];

            if (enter && !mStatus.exl) begin
                mCause.bd <= excReq.inDelaySlot;
                mEpc      <= excReq.inDelaySlot ? excReq.pc - 32'd4 : excReq.pc;
            end else if (!excReq.valid && wrOn && wrReq.addr == addrEpc) begin
                mEpc <= wrReq.data;
            end
            if (enter) mCause.excCode <= codeFor(excReq.excType);

            if (wrOn && wrReq.addr == addrCompare) mCause.ti <= 1'b0;
            else if (hit) mCause.ti <= 1'b1;
            mCause.ip72 <= intLines | (hit ? 6'b10_0000 : 6'b00_0000);
            if (wrOn && wrReq.addr == addrCause) mCause.ip10 <= wrReq.data[9:8];

            if (excReq.valid && excReq.excType == excAddrFetch) begin
                mBadVAddr <= excReq.pc;
            end else if (excReq.valid && (excReq.excType == excAddrLoad ||
                                          excReq.excType == excAddrStore)) begin
                mBadVAddr <= excReq.badAddr;
            end
        end
    end

    // Register word as the architecture lays it out
    function automatic word32T modelRead(regAddrT a);
        word32T w;
        w = '0;
        case (a)
            addrBadVAddr: w = mBadVAddr;
            addrCount:    w = mCount;
            addrCompare:  w = mCompare;
            addrEpc:      w = mEpc;
            addrStatus: begin
                w[22]   = mStatus.bev;
                w[15:8] = mStatus.im;
                w[1]    = mStatus.exl;
                w[0]    = mStatus.ie;
            end
            addrCause: begin
                w[31]    = mCause.bd;
                w[30]    = mCause.ti;
                w[15:10] = mCause.ip72;
                w[9:8]   = mCause.ip10;
                w[6:2]   = mCause.excCode;
            end
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic regAddrT randomAddr();
        logic [2:0] idx;
        idx = 3'($urandom % 6);
        if ($urandom % 2 == 0) return implAddrs[idx];
        return regAddrT'($urandom % 32);
    endfunction

    function automatic cp0WriteT makeWrite(regAddrT a, word32T d);
        cp0WriteT w;
        w.valid = 1'b1;
        w.addr  = a;
        w.data  = d;
        return w;
    endfunction

    function automatic excReqT randomExc(excTypeT t);
        excReqT e;
        e.valid       = 1'b1;
        e.excType     = t;
        e.pc          = $urandom;
        e.inDelaySlot = 1'($urandom);
        e.badAddr     = $urandom;
        return e;
    endfunction

    task automatic checkWord(word32T got, word32T exp, string msg);
        checkCount++;
        if (got !== exp) begin
            $display("ERR %0d ns: %s, got %h expected %h", $time, msg, got, exp);
            errCount++;
            testErrors++;
        end
    endtask

    task automatic checkStatus(statusFieldsT got, statusFieldsT exp, string msg);
        checkCount++;
        if (got !== exp) begin
            $display("ERR %0d ns: %s, Status got %h expected %h", $time, msg, got, exp);
            errCount++;
            testErrors++;
        end
    endtask

    task automatic checkCause(causeFieldsT got, causeFieldsT exp, string msg);
        checkCount++;
        if (got !== exp) begin
            $display("ERR %0d ns: %s, Cause got %h expected %h", $time, msg, got, exp);
            errCount++;
            testErrors++;
        end
    endtask

    task automatic nextEdge();
        @(posedge clk);
        #1;
    endtask

    // Drives one request for a single edge
    task automatic send(cp0WriteT w, excReqT e);
        wrReq  = w;
        excReq = e;
        nextEdge();
        wrReq  = '0;
        excReq = '0;
    endtask

    task automatic readAndCheck(regAddrT a, string msg);
        rdAddr = a;
        @(negedge clk);
        checkWord(rdData, modelRead(a), msg);
        checkStatus(status, mStatus, msg);
        checkCause(cause, mCause, msg);
        checkWord(epc, mEpc, msg);
    endtask

    task automatic readExpect(regAddrT a, word32T exp, string msg);
        rdAddr = a;
        @(negedge clk);
        checkWord(rdData, exp, msg);
        nextEdge();
    endtask

    task automatic endTest(string name);
        if (testErrors == 0) begin
            passTests++;
            $display("Test %s finished with no errors", name);
        end else begin
            failTests++;
            $display("Test %s finished with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic resetValuesTest();
        rdAddr = addrCount;   // Count first while it still holds zero
        @(negedge clk);
        checkWord(rdData, 32'd0, "Count after reset");
        checkStatus(status, {1'b1, 8'h00, 2'b00}, "Status after reset");
        checkCause(cause, '0, "Cause after reset");
        nextEdge();
        readExpect(addrCompare, 32'hffff_ffff, "Compare after reset");
        readExpect(addrStatus, 32'h0040_0000, "Status word after reset");
        readExpect(addrCause, 32'd0, "Cause word after reset");
        readExpect(addrEpc, 32'd0, "EPC after reset");
        readExpect(addrBadVAddr, 32'd0, "BadVAddr after reset");
        endTest("reset values");
    endtask

    task automatic writeReadTest();
        regAddrT a;
        for (int i = 0; i < writeRounds; i++) begin
            a = randomAddr();
            send(makeWrite(a, $urandom), '0);
            readAndCheck(a, "read after write");
            nextEdge();
        end
        endTest("write and read");
    endtask

    task automatic countTest();
        word32T v;
        v = $urandom;
        send(makeWrite(addrCount, v), '0);
        for (int k = 0; k < countSteps; k++) begin
            rdAddr = addrCount;
            @(negedge clk);
            checkWord(rdData, v + word32T'(k), "Count progression");
            nextEdge();
            nextEdge();
        end
        endTest("count");
    endtask

    task automatic timerTest();
        word32T c;
        logic   seen;
        c = word32T'($urandom) & 32'h0fff_ffff;
        send(makeWrite(addrCount, c), '0);
        send(makeWrite(addrCompare, c + 32'd3), '0);
        seen = 1'b0;
        for (int i = 0; i < timerWaitMax && !seen; i++) begin
            rdAddr = addrCause;
            @(negedge clk);
            checkCause(cause, mCause, "Cause while waiting for timer");
            seen = cause.ti && cause.ip72[5];
            nextEdge();
        end
        if (!seen) begin
            $display("Timer interrupt never showed up in Cause within %0d cycles", timerWaitMax);
            errCount++;
            testErrors++;
        end
        send(makeWrite(addrCompare, mCount + 32'h1000), '0);
        readAndCheck(addrCause, "Cause after Compare rewrite");
        checkWord(word32T'(cause.ti), 32'd0, "ti not cleared by Compare write");
        nextEdge();
        endTest("timer");
    endtask

    task automatic exceptionTest();
        excReqT excA;
        excReqT excB;
        word32T d;
        word32T epcBefore;
        send('0, randomExc(excEret));
        readAndCheck(addrStatus, "Status after first eret");
        nextEdge();

        // Status write in the same cycle loses EXL to the exception
        excA = randomExc(excTypeT'(4'($urandom % 9)));
        d    = word32T'($urandom) & ~32'h2;
        send(makeWrite(addrStatus, d), excA);
        epcBefore = excA.inDelaySlot ? excA.pc - 32'd4 : excA.pc;
        readAndCheck(addrEpc, "EPC after exception");
        checkWord(epc, epcBefore, "EPC of first exception");
        checkStatus(status, {d[22], d[15:8], 1'b1, d[0]}, "Status write against exception");
        nextEdge();

        // Other pc, slot and ExcCode than the first one
        excB             = randomExc(excTypeT'(4'((excA.excType + 2) % 9)));
        excB.pc          = excA.pc + 32'h100;
        excB.inDelaySlot = ~excA.inDelaySlot;
        send('0, excB);
        readAndCheck(addrCause, "Cause after nested exception");
        checkWord(epc, epcBefore, "EPC moved while EXL set");
        checkWord(word32T'(cause.bd), word32T'(excA.inDelaySlot), "BD moved while EXL set");
        checkWord(word32T'(cause.excCode), word32T'(codeFor(excB.excType)), "nested ExcCode");
        nextEdge();

        send('0, randomExc(excEret));
        readAndCheck(addrStatus, "Status after eret");
        checkWord(word32T'(status.exl), 32'd0, "EXL after eret");
        checkWord(epc, epcBefore, "EPC after eret");
        nextEdge();

        for (int i = 0; i < excRounds; i++) begin
            send(($urandom % 2) ? makeWrite(randomAddr(), $urandom) : '0,
                 randomExc(excTypeT'(4'($urandom % 10))));
            readAndCheck(implAddrs[3'($urandom % 6)], "read after random exception");
            nextEdge();
        end
        endTest("exceptions");
    endtask

    task automatic interruptTest();
        intLinesT x;
        for (int i = 0; i < intRounds; i++) begin
            x        = intLinesT'($urandom);
            intLines = x;
            @(negedge clk);
            checkCause(cause, mCause, "Cause before the lines are sampled");
            nextEdge();
            readAndCheck(addrCause, "Cause after interrupt lines");
            checkWord(word32T'(cause.ip72[4:0]), word32T'(x[4:0]), "sampled interrupt lines");
            nextEdge();
        end
        intLines = '0;
        endTest("interrupt lines");
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        wrReq      = '0;
        excReq     = '0;
        intLines   = '0;
        rdAddr     = '0;
        errCount   = 0;
        testErrors = 0;
        passTests  = 0;
        failTests  = 0;
        checkCount = 0;
        cycleCount = 0;
        void'($urandom(27917));

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        resetValuesTest();
        writeReadTest();
        countTest();
        timerTest();
        exceptionTest();
        interruptTest();

        $display("Tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 passTests, failTests, checkCount, errCount);
        if (errCount == 0 && failTests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- cp0Top.sv
`timescale 1ns/1ps

module cp0Top import cp0RegPkg::*, trapPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  cp0WriteT     wrReq,
    input  excReqT       excReq,
    input  intLinesT     intLines,
    input  regAddrT      rdAddr,
    output word32T       rdData,
    output statusFieldsT status,
    output causeFieldsT  cause,
    output word32T       epc
);

    cp0StrobeT strobes;
    excActionT excAction;
    word32T    count;
    word32T    compare;
    word32T    badVAddr;
    logic      timerHit;

    cp0Decode i_cp0Decode (
        .wrReq     (wrReq),
        .excReq    (excReq),
        .strobes   (strobes),
        .excAction (excAction)
    );

    cp0Timer i_cp0Timer (
        .clk      (clk),
        .reset    (reset),
        .strobes  (strobes),
        .count    (count),
        .compare  (compare),
        .timerHit (timerHit)
    );

    cp0ExcState i_cp0ExcState (
        .clk       (clk),
        .reset     (reset),
        .strobes   (strobes),
        .excAction (excAction),
        .excReq    (excReq),
        .intLines  (intLines),
        .timerHit  (timerHit),
        .status    (status),
        .cause     (cause),
        .epc       (epc),
        .badVAddr  (badVAddr)
    );

    cp0ReadMux i_cp0ReadMux (
        .rdAddr   (rdAddr),
        .status   (status),
        .cause    (cause),
        .epc      (epc),
        .badVAddr (badVAddr),
        .count    (count),
        .compare  (compare),
        .rdData   (rdData)
    );

endmodule

//--- cp0ReadMux.sv
`timescale 1ns/1ps

module cp0ReadMux import cp0RegPkg::*; (
    input  regAddrT      rdAddr,
    input  statusFieldsT status,
    input  causeFieldsT  cause,
    input  word32T       epc,
    input  word32T       badVAddr,
    input  word32T       count,
    input  word32T       compare,
    output word32T       rdData
);

    word32T statusWord;
    word32T causeWord;

    // Architectural bit positions
    assign statusWord = {9'b0, status.bev, 6'b0, status.im, 6'b0, status.exl, status.ie};
    assign causeWord  = {cause.bd, cause.ti, 14'b0, cause.ip72, cause.ip10,
                         1'b0, cause.excCode, 2'b0};

    always_comb begin
        case (rdAddr)
            addrBadVAddr: rdData = badVAddr;
            addrCount:    rdData = count;
            addrCompare:  rdData = compare;
            addrStatus:   rdData = statusWord;
            addrCause:    rdData = causeWord;
            addrEpc:      rdData = epc;
            default:      rdData = '0;   // Unimplemented
        endcase
    end

endmodule

//--- cp0ExcState.sv
`timescale 1ns/1ps

module cp0ExcState import cp0RegPkg::*, trapPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  cp0StrobeT    strobes,
    input  excActionT    excAction,
    input  excReqT       excReq,
    input  intLinesT     intLines,
    input  logic         timerHit,
    output statusFieldsT status,
    output causeFieldsT  cause,
    output word32T       epc,
    output word32T       badVAddr
);

    logic   excActive;
    logic   firstLevel;   // Not already inside a handler
    word32T restartPc;

    assign excActive  = excAction.enter | excAction.eret;
    assign firstLevel = ~status.exl;
    assign restartPc  = excReq.inDelaySlot ? excReq.pc - 32'd4 : excReq.pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            status.bev <= 1'b1;
            status.im  <= '0;
            status.exl <= 1'b0;
            status.ie  <= 1'b0;
        end else begin
            if (strobes.status) begin
                status.bev <= strobes.data[22];
                status.im  <= strobes.data[15:8];
                status.ie  <= strobes.data[0];
            end
            // Exceptions take EXL over a software write
            if (excAction.enter) begin
                status.exl <= 1'b1;
            end else if (excAction.eret) begin
                status.exl <= 1'b0;
            end else if (strobes.status) begin
                status.exl <= strobes.data[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause <= '0;
        end else begin
            if (excAction.enter && firstLevel) cause.bd <= excReq.inDelaySlot;
            if (excAction.enter) cause.excCode <= excAction.code;

            if (strobes.compare) begin
                cause.ti <= 1'b0;   // Acknowledges the timer
            end else if (timerHit) begin
                cause.ti <= 1'b1;
            end

            cause.ip72 <= intLines | {timerHit, 5'b0};   // Timer shares IP7
            if (strobes.cause) cause.ip10 <= strobes.data[9:8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (excActive) begin
            if (excAction.enter && firstLevel) epc <= restartPc;
        end else if (strobes.epc) begin
            epc <= strobes.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr <= '0;
        end else if (excAction.loadBadVAddr) begin
            badVAddr <= excAction.badVAddr;
        end
    end

endmodule

//--- cp0Timer.sv
`timescale 1ns/1ps

module cp0Timer import cp0RegPkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  cp0StrobeT strobes,
    output word32T    count,
    output word32T    compare,
    output logic      timerHit
);

    logic phase;   // Count advances when this is set

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 1'b0;
        end else if (strobes.count) begin
            phase <= 1'b0;
        end else begin
            phase <= ~phase;
        end
    end

    // Half-rate counter
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= countResetVal;
        end else if (strobes.count) begin
            count <= strobes.data;
        end else if (phase) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= compareResetVal;
        end else if (strobes.compare) begin
            compare <= strobes.data;
        end
    end

    // Stays high for as long as the values match
    assign timerHit = (count == compare);

endmodule

//--- cp0Decode.sv
`timescale 1ns/1ps

module cp0Decode import cp0RegPkg::*, trapPkg::*; (
    input  cp0WriteT  wrReq,
    input  excReqT    excReq,
    output cp0StrobeT strobes,
    output excActionT excAction
);

    // BadVAddr gets no strobe
    always_comb begin
        strobes.count   = wrReq.valid && (wrReq.addr == addrCount);
        strobes.compare = wrReq.valid && (wrReq.addr == addrCompare);
        strobes.status  = wrReq.valid && (wrReq.addr == addrStatus);
        strobes.cause   = wrReq.valid && (wrReq.addr == addrCause);
        strobes.epc     = wrReq.valid && (wrReq.addr == addrEpc);
        strobes.data    = wrReq.data;
    end

    always_comb begin
        excAction.enter        = excReq.valid && (excReq.excType != excEret);
        excAction.eret         = excReq.valid && (excReq.excType == excEret);
        excAction.loadBadVAddr = 1'b0;
        excAction.badVAddr     = excReq.badAddr;

        case (excReq.excType)
            excInterrupt: excAction.code = codeInt;
            excAddrFetch: excAction.code = codeAdEL;
            excAddrLoad:  excAction.code = codeAdEL;
            excAddrStore: excAction.code = codeAdES;
            excReserved:  excAction.code = codeRi;
            excSyscall:   excAction.code = codeSys;
            excBreak:     excAction.code = codeBp;
            excTrap:      excAction.code = codeTr;
            excOverflow:  excAction.code = codeOv;
            default:      excAction.code = codeInt;   // Not used by eret
        endcase

        // Address errors also capture the faulting address
        case (excReq.excType)
            excAddrFetch: begin
                excAction.loadBadVAddr = excReq.valid;
                excAction.badVAddr     = excReq.pc;
            end
            excAddrLoad, excAddrStore: begin
                excAction.loadBadVAddr = excReq.valid;
            end
            default: begin
                excAction.loadBadVAddr = 1'b0;
            end
        endcase
    end

endmodule

//--- trapPkg.sv
package trapPkg;

    import cp0RegPkg::*;

    typedef enum logic [3:0] {
        excInterrupt,
        excAddrFetch,    // Misaligned instruction fetch
        excAddrLoad,
        excAddrStore,
        excReserved,
        excSyscall,
        excBreak,
        excTrap,
        excOverflow,
        excEret
    } excTypeT;

    // ExcCode values written into Cause
    localparam excCodeT codeInt  = 5'd0;
    localparam excCodeT codeAdEL = 5'd4;
    localparam excCodeT codeAdES = 5'd5;
    localparam excCodeT codeSys  = 5'd8;
    localparam excCodeT codeBp   = 5'd9;
    localparam excCodeT codeRi   = 5'd10;
    localparam excCodeT codeOv   = 5'd12;
    localparam excCodeT codeTr   = 5'd13;

    typedef struct packed {
        logic    valid;
        excTypeT excType;
        word32T  pc;
        logic    inDelaySlot;
        word32T  badAddr;   // Faulting data address
    } excReqT;

    // Decoded register updates for one exception request
    typedef struct packed {
        logic    enter;     // Any exception other than eret
        logic    eret;
        excCodeT code;
        logic    loadBadVAddr;
        word32T  badVAddr;
    } excActionT;

endpackage

//--- cp0RegPkg.sv
package cp0RegPkg;

    // Widths with a meaning of their own
    typedef logic [4:0]  regAddrT;
    typedef logic [31:0] word32T;
    typedef logic [5:0]  intLinesT;   // Hardware interrupt lines
    typedef logic [7:0]  imaskT;
    typedef logic [4:0]  excCodeT;

    // Implemented register numbers at select 0
    localparam regAddrT addrBadVAddr = 5'd8;
    localparam regAddrT addrCount    = 5'd9;
    localparam regAddrT addrCompare  = 5'd11;
    localparam regAddrT addrStatus   = 5'd12;
    localparam regAddrT addrCause    = 5'd13;
    localparam regAddrT addrEpc      = 5'd14;

    localparam word32T countResetVal   = '0;
    localparam word32T compareResetVal = '1;   // Keeps the timer quiet after reset

    typedef struct packed {
        logic  bev;
        imaskT im;
        logic  exl;
        logic  ie;
    } statusFieldsT;

    typedef struct packed {
        logic     bd;
        logic     ti;
        intLinesT ip72;   // Bit 5 also carries the timer
        logic [1:0] ip10; // Software interrupts
        excCodeT  excCode;
    } causeFieldsT;

    // Move-to-coprocessor request from the memory stage
    typedef struct packed {
        logic    valid;
        regAddrT addr;
        word32T  data;
    } cp0WriteT;

    // One enable per writable register
    typedef struct packed {
        logic   count;
        logic   compare;
        logic   status;
        logic   cause;
        logic   epc;
        word32T data;
    } cp0StrobeT;

endpackage
